// ==== vnu_ctrl.f ====
+incdir+design
design/vnu_ctrl_pkg.sv
design/ib_load_handshake.sv
design/vnu_sched_fsm.sv
design/sched_strobe_decode.sv
design/vnu_control_unit.sv
dv/vnu_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vnu control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module vnu_ctrl_tb \
	-f vnu_ctrl.f -o vnu_ctrl_sim

sim_out=$(./obj_dir/vnu_ctrl_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== dv/vnu_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "vnu_ctrl_params.svh"

module vnu_ctrl_tb import vnu_ctrl_pkg::*; ();

	localparam int NU             = `VNU_FUNC_NUM + 1;  // vnu units then the dnu
	localparam int STB_W          = 8 + `VNU_FUNC_NUM;
	localparam int ACK_DELAY_SPAN = 7;   // writer answers 0..6 cycles after wr rises
	localparam int BP_DELAY       = 20;  // long enough to outlast the rest of a layer
	localparam int PEND_LIMIT     = 40;
	// about eight layers of 16 cycles, load waits of up to 25, well inside this
	localparam int TIMEOUT_CYCLES = 2000;

	logic                     read_clk;
	logic                     rstn;
	logic                     fsm_en_i;
	logic                     termination_i;
	logic                     layer_finish_i;
	logic [`VNU_FUNC_NUM-1:0] vn_iter_update_i;
	logic                     dn_iter_update_i;
	sched_state_e             state_o;
	logic [`LAYER_NUM-1:0]    layer_cnt_o;
	logic                     last_layer_o;
	logic                     vnu_update_pend_o;
	logic                     hard_decision_done_o;
	logic [`VNU_FUNC_NUM-1:0] vnu_wr_o;
	logic [`VNU_FUNC_NUM-1:0] vnu_rd_o;
	logic                     dnu_wr_o;
	logic                     dnu_rd_o;
	logic                     ch_ram_fetch_o;
	logic                     c2v_mem_fetch_o;
	logic                     v2c_src_o;
	logic                     v2c_bs_en_o;
	logic                     v2c_pa_en_o;
	logic                     v2c_mem_we_o;

	logic [NU-1:0] wr_all;
	assign wr_all = {dnu_wr_o, vnu_wr_o};

	int           n_checks;
	int           n_errors;
	int           layer_idx;             // expected position of the layer one-hot
	int           forced_delay = -1;     // vnu ack delay override, -1 picks a random one
	int unsigned  lcg_state    = 32'h5c7c;
	int           cycle_cnt;
	sched_state_e seq_state[20];         // expected phase of each cycle of a layer
	int           seq_phase[20];
	int           seq_len;

	// writer model state per unit
	bit wr_seen[NU];
	bit ack_seen[NU];
	bit ack_pend[NU];
	bit rel_due[NU];   // wr has to be gone at the next sample
	int hi_cnt[NU];
	int ack_wait[NU];
	int rel_cyc[NU];   // first cycle the write should be low again

	vnu_control_unit i_dut (.*);

	initial begin
		read_clk = 1'b0;
		forever #5 read_clk = ~read_clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic next_cycle();
		@(posedge read_clk);
		#1;  // outputs settled, inputs change here
	endtask

	task automatic note_failure(input string msg);
		n_errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		n_checks++;
		if (act_v !== exp_v) begin
			n_errors++;
			$display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
		end
	endtask

	function automatic int unsigned lcg_step();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic add_phase(input sched_state_e s, input int len);
		for (int p = 0; p < len; p++) begin
			seq_state[seq_len] = s;
			seq_phase[seq_len] = p;
			seq_len++;
		end
	endtask

	task automatic build_schedule();
		seq_len = 0;
		add_phase(CH_FETCH, 1);
		add_phase(CH_BUBBLE, `CH_BUBBLE_CYCLES);
		add_phase(MEM_FETCH, `MEM_RD_CYCLES);
		add_phase(VNU_PIPE, `VNU_PIPE_CYCLES);
		add_phase(VNU_OUT, 1);
		add_phase(BS_WB, `BS_CYCLES);
		add_phase(PAGE_ALIGN, 1);
		add_phase(MEM_WB, 1);
		add_phase(IDLE, 1);  // first idle cycle, everything quiet
	endtask

	// vnu step: pipe cycles, then VNU_OUT as one more step
	function automatic int step_index(sched_state_e s, int ph);
		if (s == VNU_PIPE) return ph;
		if (s == VNU_OUT) return `VNU_PIPE_CYCLES;
		return -1;
	endfunction

	function automatic logic [STB_W-1:0] expected_strobes(sched_state_e s, int ph, logic last);
		logic [`VNU_FUNC_NUM-1:0] rd;
		int step;
		step = step_index(s, ph);
		for (int j = 0; j < `VNU_FUNC_NUM; j++) begin
			rd[j] = (step >= `VNU_FUNC_CYCLE * j) && (step < `VNU_FUNC_CYCLE * (j + 1));
		end
		return {s == CH_FETCH, (s == MEM_FETCH) && (ph == 0), (s == MEM_FETCH) && (ph == 1),
			rd, (s == BS_WB) && (ph == 0), (s == BS_WB) || (s == PAGE_ALIGN),
			s == PAGE_ALIGN, s == MEM_WB, last && (s == PAGE_ALIGN)};
	endfunction

	function automatic logic [STB_W-1:0] sampled_strobes();
		return {ch_ram_fetch_o, c2v_mem_fetch_o, v2c_src_o, vnu_rd_o, v2c_bs_en_o,
			dnu_rd_o, v2c_pa_en_o, v2c_mem_we_o, hard_decision_done_o};
	endfunction

	//////////////////////////////
	// IB-RAM writer model
	//////////////////////////////
	// answers each rising wr, and watches hold time and release
	task automatic track_write(input int u, output logic ack);
		logic wr_now;
		wr_now = wr_all[u];
		ack    = 1'b0;
		if (wr_seen[u] && !wr_now && !rel_due[u])
			note_failure($sformatf("unit %0d write fell before hold time and ack", u));
		if (wr_seen[u] && wr_now && rel_due[u])
			note_failure($sformatf("unit %0d write still high after hold time and ack", u));
		if (wr_now && !wr_seen[u]) begin
			hi_cnt[u]   = 1;
			ack_seen[u] = 1'b0;
			ack_pend[u] = 1'b1;
			if ((u < `VNU_FUNC_NUM) && (forced_delay >= 0))
				ack_wait[u] = forced_delay;
			else
				ack_wait[u] = int'((lcg_step() >> 16) % ACK_DELAY_SPAN);
			// write drops once both the hold time and the ack lie behind it
			rel_cyc[u] = cycle_cnt + ((ack_wait[u] >= `LOAD_HANDSHAKE_LATENCY) ?
				ack_wait[u] + 1 : `LOAD_HANDSHAKE_LATENCY);
		end else if (wr_now) begin
			hi_cnt[u]++;
		end
		if (ack_pend[u]) begin
			if (ack_wait[u] == 0) begin
				ack         = 1'b1;  // one cycle acknowledge
				ack_pend[u] = 1'b0;
				ack_seen[u] = 1'b1;
			end else begin
				ack_wait[u]--;
			end
		end
		rel_due[u] = wr_now && (hi_cnt[u] >= `LOAD_HANDSHAKE_LATENCY) && ack_seen[u];
		wr_seen[u] = wr_now;
	endtask

	// any vnu write the writer model still expects high in this cycle
	function automatic bit vnu_load_pending();
		bit pend;
		pend = 1'b0;
		for (int u = 0; u < `VNU_FUNC_NUM; u++) begin
			if (cycle_cnt < rel_cyc[u])
				pend = 1'b1;
		end
		return pend;
	endfunction

	initial begin : ib_writer
		logic [NU-1:0] ack;
		vn_iter_update_i = '0;
		dn_iter_update_i = 1'b0;
		forever begin
			next_cycle();
			for (int u = 0; u < NU; u++) begin
				track_write(u, ack[u]);  // fixed unit order keeps the random draws stable
			end
			vn_iter_update_i = ack[`VNU_FUNC_NUM-1:0];
			dn_iter_update_i = ack[NU-1];
		end
	end

	//////////////////////////////
	// layer steps
	//////////////////////////////
	// call in IB_RAM_PEND, returns in CH_FETCH
	task automatic await_ib_release(input string name);
		int n;
		n = 0;
		while (vnu_update_pend_o && (n < PEND_LIMIT)) begin
			compare_value({name, " pend state"}, IB_RAM_PEND, state_o);
			next_cycle();
			n++;
		end
		if (n >= PEND_LIMIT) note_failure({name, ": vnu IB-RAM load never finished"});
		compare_value({name, " state at release"}, IB_RAM_PEND, state_o);
		compare_value({name, " vnu_wr at release"}, 0, vnu_wr_o);
		next_cycle();
		compare_value({name, " state after release"}, CH_FETCH, state_o);
	endtask

	// call in CH_FETCH, returns in the first IDLE cycle
	task automatic walk_layer(input string name);
		logic          last;
		logic [NU-1:0] wr_prev;
		int            step;
		last    = (layer_idx == `LAYER_NUM - 1);
		wr_prev = wr_all;
		compare_value({name, " last_layer"}, last, last_layer_o);
		for (int i = 0; i < seq_len; i++) begin
			if (i > 0) next_cycle();
			compare_value($sformatf("%s state[%0d]", name, i), seq_state[i], state_o);
			compare_value($sformatf("%s strobes[%0d]", name, i),
				expected_strobes(seq_state[i], seq_phase[i], last), sampled_strobes());
			compare_value({name, " layer_cnt"}, 1 << layer_idx, layer_cnt_o);
			step = step_index(seq_state[i], seq_phase[i]);
			if (!last) begin
				compare_value({name, " vnu_wr"}, 0, vnu_wr_o);
				compare_value({name, " dnu_wr no rise"}, 0,
					wr_all[NU-1] && !wr_prev[NU-1]);
			end else begin
				for (int j = 0; j < `VNU_FUNC_NUM; j++) begin
					// start at step 3j+1, write one cycle later
					if (step == `VNU_FUNC_CYCLE * j + 2)
						compare_value($sformatf("%s vnu_wr[%0d] rise", name, j), 2'b01,
							{wr_prev[j], wr_all[j]});
				end
				if (seq_state[i] == PAGE_ALIGN)
					compare_value({name, " dnu_wr rise"}, 2'b01, {wr_prev[NU-1], wr_all[NU-1]});
			end
			wr_prev = wr_all;
		end
	endtask

	// call in IDLE, returns in CH_FETCH
	task automatic end_layer(input string name, input int idle_cycles);
		logic         pend;
		sched_state_e exp_next;
		repeat (idle_cycles) begin
			next_cycle();
			compare_value({name, " idle hold"}, IDLE, state_o);
			compare_value({name, " idle strobes"}, 0, sampled_strobes());
		end
		layer_finish_i = 1'b1;
		pend           = vnu_load_pending();
		compare_value({name, " pend at finish"}, pend, vnu_update_pend_o);
		exp_next       = pend ? IB_RAM_PEND : CH_FETCH;
		layer_idx      = (layer_idx + 1) % `LAYER_NUM;
		next_cycle();
		layer_finish_i = 1'b0;
		compare_value({name, " state after finish"}, exp_next, state_o);
		compare_value({name, " layer rotation"}, 1 << layer_idx, layer_cnt_o);
		if (exp_next == IB_RAM_PEND) await_ib_release(name);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic reset_defaults();
		repeat (3) begin
			next_cycle();
			compare_value("reset state", INIT_LOAD, state_o);
			compare_value("reset strobes", 0, sampled_strobes());
			compare_value("reset writes", 0, wr_all);
			compare_value("reset layer_cnt", 1, layer_cnt_o);
			compare_value("reset last_layer", 0, last_layer_o);
			compare_value("reset pend", 0, vnu_update_pend_o);
		end
	endtask

	task automatic initial_load();
		fsm_en_i = 1'b1;
		next_cycle();
		compare_value("init_load state", IB_RAM_PEND, state_o);
		compare_value("init_load writes", (1 << NU) - 1, wr_all);  // every unit loads
		compare_value("init_load pend", 1, vnu_update_pend_o);
		await_ib_release("init_load");
	endtask

	task automatic layer_phase_walk();
		walk_layer("phase_walk");
		end_layer("phase_walk", 3);
	endtask

	task automatic last_layer_rotation();
		walk_layer("rotation layer1");
		end_layer("rotation layer1", 1);
		walk_layer("rotation last");  // hard decision and pipe loads here
		end_layer("rotation last", 0);
	endtask

	task automatic ack_back_pressure();
		while (layer_idx != `LAYER_NUM - 1) begin
			walk_layer("bp warmup");
			end_layer("bp warmup", 0);
		end
		forced_delay = BP_DELAY;
		walk_layer("back_pressure");
		compare_value("back_pressure pend in idle", 1, vnu_update_pend_o);
		end_layer("back_pressure", 0);  // goes through IB_RAM_PEND
		forced_delay = -1;
	endtask

	task automatic mid_layer_termination();
		repeat (1 + `CH_BUBBLE_CYCLES + `MEM_RD_CYCLES) next_cycle();
		compare_value("termination entry", VNU_PIPE, state_o);
		termination_i = 1'b1;
		next_cycle();
		compare_value("termination state", INIT_LOAD, state_o);
		next_cycle();
		compare_value("termination parked", INIT_LOAD, state_o);
		compare_value("termination no load", 0, wr_all);
		termination_i = 1'b0;
		next_cycle();
		compare_value("termination reload state", IB_RAM_PEND, state_o);
		compare_value("termination reload writes", (1 << NU) - 1, wr_all);
		await_ib_release("termination");
		walk_layer("termination restart");
		end_layer("termination restart", 0);
	endtask

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge read_clk);
			cycle_cnt++;
		end
		$display("timeout: run stopped after %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		rstn           = 1'b0;
		fsm_en_i       = 1'b0;
		termination_i  = 1'b0;
		layer_finish_i = 1'b0;
		n_checks       = 0;
		n_errors       = 0;
		layer_idx      = 0;
		build_schedule();
		repeat (2) next_cycle();  // reset for two cycles
		rstn = 1'b1;
		reset_defaults();
		initial_load();
		layer_phase_walk();
		last_layer_rotation();
		ack_back_pressure();
		mid_layer_termination();
		next_cycle();
		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== design/vnu_control_unit.sv ====
`timescale 1ns/1ps
`include "vnu_ctrl_params.svh"

module vnu_control_unit import vnu_ctrl_pkg::*; (
	input  logic                     read_clk,
	input  logic                     rstn,
	input  logic                     fsm_en_i,
	input  logic                     termination_i,
	input  logic                     layer_finish_i,
	input  logic [`VNU_FUNC_NUM-1:0] vn_iter_update_i,  // vnu writer acknowledges
	input  logic                     dn_iter_update_i,  // dnu writer acknowledge
	output sched_state_e             state_o,
	output logic [`LAYER_NUM-1:0]    layer_cnt_o,
	output logic                     last_layer_o,
	output logic                     vnu_update_pend_o,
	output logic                     hard_decision_done_o,
	output logic [`VNU_FUNC_NUM-1:0] vnu_wr_o,
	output logic [`VNU_FUNC_NUM-1:0] vnu_rd_o,
	output logic                     dnu_wr_o,
	output logic                     dnu_rd_o,
	output logic                     ch_ram_fetch_o,
	output logic                     c2v_mem_fetch_o,
	output logic                     v2c_src_o,
	output logic                     v2c_bs_en_o,
	output logic                     v2c_pa_en_o,
	output logic                     v2c_mem_we_o
);

	logic [`PHASE_CNT_W-1:0]  phase_cnt;
	logic [`VNU_FUNC_NUM-1:0] vnu_load_start;
	logic [`VNU_FUNC_NUM-1:0] vnu_busy;
	logic                     dnu_load_start;
	logic                     ib_busy;  // any vnu IB-RAM still loading

	assign ib_busy           = |vnu_busy;
	assign vnu_update_pend_o = ib_busy;

	////////////////////////////////
	// scheduler and strobes
	////////////////////////////////
	vnu_sched_fsm i_fsm (
		.read_clk       (read_clk),
		.rstn           (rstn),
		.fsm_en_i       (fsm_en_i),
		.termination_i  (termination_i),
		.layer_finish_i (layer_finish_i),
		.ib_busy_i      (ib_busy),
		.state_o        (state_o),
		.phase_cnt_o    (phase_cnt),
		.layer_cnt_o    (layer_cnt_o),
		.last_layer_o   (last_layer_o)
	);

	sched_strobe_decode i_decode (
		.read_clk             (read_clk),
		.rstn                 (rstn),
		.state_i              (state_o),
		.phase_cnt_i          (phase_cnt),
		.last_layer_i         (last_layer_o),
		.vnu_load_start_o     (vnu_load_start),
		.dnu_load_start_o     (dnu_load_start),
		.hard_decision_done_o (hard_decision_done_o),
		.vnu_rd_o             (vnu_rd_o),
		.dnu_rd_o             (dnu_rd_o),
		.ch_ram_fetch_o       (ch_ram_fetch_o),
		.c2v_mem_fetch_o      (c2v_mem_fetch_o),
		.v2c_src_o            (v2c_src_o),
		.v2c_bs_en_o          (v2c_bs_en_o),
		.v2c_pa_en_o          (v2c_pa_en_o),
		.v2c_mem_we_o         (v2c_mem_we_o)
	);

	////////////////////////////////
	// IB-RAM load handshakes
	////////////////////////////////
	for (genvar j = 0; j < `VNU_FUNC_NUM; j++) begin : g_vnu_hs
		ib_load_handshake i_vnu_hs (
			.read_clk      (read_clk),
			.rstn          (rstn),
			.load_start_i  (vnu_load_start[j]),
			.iter_update_i (vn_iter_update_i[j]),
			.wr_o          (vnu_wr_o[j]),
			.busy_o        (vnu_busy[j])
		);
	end

	// dnu refresh never stalls the schedule
	ib_load_handshake i_dnu_hs (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.load_start_i  (dnu_load_start),
		.iter_update_i (dn_iter_update_i),
		.wr_o          (dnu_wr_o),
		.busy_o        ()
	);

endmodule

// ==== design/sched_strobe_decode.sv ====
`timescale 1ns/1ps
`include "vnu_ctrl_params.svh"

module sched_strobe_decode import vnu_ctrl_pkg::*; (
	input  logic                     read_clk,
	input  logic                     rstn,
	input  sched_state_e             state_i,
	input  logic [`PHASE_CNT_W-1:0]  phase_cnt_i,
	input  logic                     last_layer_i,
	output logic [`VNU_FUNC_NUM-1:0] vnu_load_start_o,
	output logic                     dnu_load_start_o,
	output logic                     hard_decision_done_o,
	output logic [`VNU_FUNC_NUM-1:0] vnu_rd_o,
	output logic                     dnu_rd_o,
	output logic                     ch_ram_fetch_o,
	output logic                     c2v_mem_fetch_o,
	output logic                     v2c_src_o,
	output logic                     v2c_bs_en_o,
	output logic                     v2c_pa_en_o,
	output logic                     v2c_mem_we_o
);

	localparam int PW        = `PHASE_CNT_W;
	localparam int SW        = $clog2(`VNU_PIPE_CYCLES + 1);  // vnu step width
	localparam int START_OFS = 1;  // pipe load starts one step into each function window

	localparam logic [PW-1:0] MEM_SRC = PW'(`MEM_RD_CYCLES - 1);
	localparam logic [PW-1:0] BS_LAST = PW'(`BS_CYCLES - 1);

	logic          init_start;  // one cycle of INIT_LOAD with the FSM running
	logic          vnu_act;     // VNU_PIPE or VNU_OUT
	logic [SW-1:0] vnu_step;
	logic          bs_last;
	logic          hd_q;

	assign init_start = (state_i == INIT_LOAD) && (phase_cnt_i == '0);
	assign vnu_act    = (state_i >= VNU_PIPE) && (state_i <= VNU_OUT);
	assign vnu_step   = (state_i == VNU_OUT) ? SW'(`VNU_PIPE_CYCLES) : SW'(phase_cnt_i);
	assign bs_last    = (state_i == BS_WB) && (phase_cnt_i == BS_LAST);

	////////////////////////////////
	// vnu read windows and pipe loads
	////////////////////////////////
	for (genvar j = 0; j < `VNU_FUNC_NUM; j++) begin : g_vnu
		localparam int LO = `VNU_FUNC_CYCLE * j;  // first step of function j

		assign vnu_rd_o[j] = vnu_act && (vnu_step >= SW'(LO))
			&& (vnu_step <= SW'(LO + `VNU_FUNC_CYCLE - 1));
		// refresh of unit j, staggered behind its read window
		assign vnu_load_start_o[j] = init_start
			|| (last_layer_i && vnu_act && (vnu_step == SW'(LO + START_OFS)));
	end

	assign dnu_load_start_o = init_start || (last_layer_i && bs_last);
	assign dnu_rd_o         = (state_i >= BS_WB) && (state_i <= PAGE_ALIGN); // dnu spans BS_WB..PAGE_ALIGN

	// phase strobes
	assign ch_ram_fetch_o  = (state_i == CH_FETCH);
	assign c2v_mem_fetch_o = (state_i == MEM_FETCH) && (phase_cnt_i == '0);
	assign v2c_src_o       = (state_i == MEM_FETCH) && (phase_cnt_i == MEM_SRC);
	assign v2c_bs_en_o     = (state_i == BS_WB) && (phase_cnt_i == '0); // first shifter stage only
	assign v2c_pa_en_o     = (state_i == PAGE_ALIGN);
	assign v2c_mem_we_o    = (state_i == MEM_WB);

	// hard decision lands in PAGE_ALIGN of the last layer
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			hd_q <= 1'b0;
		end else begin
			hd_q <= last_layer_i && bs_last;
		end
	end

	assign hard_decision_done_o = hd_q;

	a_we_bs_excl: assert property (@(posedge read_clk) disable iff (!rstn)
		!(v2c_mem_we_o && v2c_bs_en_o))
		else $error("sched_strobe_decode: v2c write and barrel shift overlap");

endmodule

// ==== design/vnu_sched_fsm.sv ====
`timescale 1ns/1ps
`include "vnu_ctrl_params.svh"

module vnu_sched_fsm import vnu_ctrl_pkg::*; (
	input  logic                    read_clk,
	input  logic                    rstn,
	input  logic                    fsm_en_i,
	input  logic                    termination_i,   // frame decoded, start over
	input  logic                    layer_finish_i,  // end of layer from the datapath
	input  logic                    ib_busy_i,       // a vnu IB-RAM load is still running
	output sched_state_e            state_o,
	output logic [`PHASE_CNT_W-1:0] phase_cnt_o,     // cycles spent in state_o
	output logic [`LAYER_NUM-1:0]   layer_cnt_o,     // layer one-hot
	output logic                    last_layer_o
);

	localparam int PW = `PHASE_CNT_W;

	// last phase cycle of each timed state
	localparam logic [PW-1:0] BUB_LAST   = PW'(`CH_BUBBLE_CYCLES - 1);
	localparam logic [PW-1:0] MEM_LAST   = PW'(`MEM_RD_CYCLES - 1);
	localparam logic [PW-1:0] PIPE_LAST  = PW'(`VNU_PIPE_CYCLES - 1);
	localparam logic [PW-1:0] BS_LAST    = PW'(`BS_CYCLES - 1);
	localparam logic [PW-1:0] PHASE_PARK = '1; // shown while parked in INIT_LOAD

	sched_state_e           state_q;
	sched_state_e           state_d;
	logic [PW-1:0]          phase_q;
	logic [`LAYER_NUM-1:0]  layer_q;
	logic                   run;        // enabled and not terminated
	logic                   layer_rot;

	assign run       = fsm_en_i && !termination_i;
	assign layer_rot = run && (state_q == IDLE) && layer_finish_i;

	////////////////////////////////
	// next phase
	////////////////////////////////
	always_comb begin
		state_d = state_q;
		if (!run) begin
			state_d = INIT_LOAD;  // disable or termination restarts the frame
		end else begin
			case (state_q)
				INIT_LOAD:   state_d = IB_RAM_PEND;
				IB_RAM_PEND: if (!ib_busy_i) state_d = CH_FETCH;
				CH_FETCH:    state_d = CH_BUBBLE;
				CH_BUBBLE:   if (phase_q == BUB_LAST) state_d = MEM_FETCH;
				MEM_FETCH:   if (phase_q == MEM_LAST) state_d = VNU_PIPE;
				VNU_PIPE:    if (phase_q == PIPE_LAST) state_d = VNU_OUT;
				VNU_OUT:     state_d = BS_WB;
				BS_WB:       if (phase_q == BS_LAST) state_d = PAGE_ALIGN;
				PAGE_ALIGN:  state_d = MEM_WB;
				MEM_WB:      state_d = IDLE;
				IDLE: begin
					if (layer_finish_i) begin
						// pipe load from the last layer may still be writing
						state_d = ib_busy_i ? IB_RAM_PEND : CH_FETCH;
					end
				end
				default:     state_d = INIT_LOAD;
			endcase
		end
	end

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= INIT_LOAD;
		end else begin
			state_q <= state_d;
		end
	end

	// phase cycle counter, 0 on entry to every state
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			phase_q <= '0;
		end else if (!run || (state_d != state_q)) begin
			phase_q <= '0;
		end else if (phase_q != '1) begin
			phase_q <= phase_q + 1'b1;  // saturates in the open ended waits
		end
	end

	// layer one-hot, rotates when a layer ends in IDLE
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			layer_q <= `LAYER_NUM'(1);
		end else if (layer_rot) begin
			layer_q <= {layer_q[`LAYER_NUM-2:0], layer_q[`LAYER_NUM-1]};
		end
	end

	assign state_o      = state_q;
	// while parked the decoder sees no phase 0, so no load is kicked off
	assign phase_cnt_o  = ((state_q == INIT_LOAD) && !run) ? PHASE_PARK : phase_q;
	assign layer_cnt_o  = layer_q;
	assign last_layer_o = layer_q[`LAYER_NUM-1];

	////////////////////////////////
	// checks
	////////////////////////////////
	a_layer_onehot: assert property (@(posedge read_clk) disable iff (!rstn)
		$onehot(layer_q))
		else $error("vnu_sched_fsm: layer one-hot lost");

	a_pend_hold: assert property (@(posedge read_clk) disable iff (!rstn)
		(state_q == IB_RAM_PEND && ib_busy_i && run) |=> (state_q == IB_RAM_PEND))
		else $error("vnu_sched_fsm: left IB_RAM_PEND while IB-RAM busy");

endmodule

// ==== design/ib_load_handshake.sv ====
`timescale 1ns/1ps
`include "vnu_ctrl_params.svh"

module ib_load_handshake (
	input  logic read_clk,
	input  logic rstn,
	input  logic load_start_i,   // one cycle start from the strobe decoder
	input  logic iter_update_i,  // writer acknowledge
	output logic wr_o,           // write request to the IB-RAM writer
	output logic busy_o
);

	localparam int LAT = `LOAD_HANDSHAKE_LATENCY;
	localparam int CW  = $clog2(LAT + 1);

	logic          busy_q;  // load in flight
	logic [CW-1:0] hold_q;  // cycles wr has been high, stops at LAT
	logic          ack_q;   // acknowledge seen before the hold time ran out
	logic          held;
	logic          done;

	assign held = (hold_q >= CW'(LAT));
	assign done = busy_q && held && (iter_update_i || ack_q); // release on this edge

	////////////////////////////////
	// request / hold / release
	////////////////////////////////
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			hold_q <= '0;
			ack_q  <= 1'b0;
		end else if (!busy_q) begin
			busy_q <= load_start_i;                // wr rises the cycle after start
			hold_q <= load_start_i ? CW'(1) : '0;  // first high cycle counts as one
			ack_q  <= 1'b0;
		end else if (done) begin
			busy_q <= 1'b0;  // wr and busy fall together
			hold_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			if (!held) begin
				hold_q <= hold_q + 1'b1;
			end
			ack_q <= ack_q | iter_update_i;  // an early ack waits for the hold time
		end
	end

	// starts arriving while busy fall into the busy branch and are dropped
	assign wr_o   = busy_q;
	assign busy_o = busy_q;

	// once raised, the write request stays up for the full hold time
	a_wr_min_hold: assert property (@(posedge read_clk) disable iff (!rstn)
		$rose(wr_o) |-> wr_o [*LAT])
		else $error("ib_load_handshake: wr_o fell before %0d cycles", LAT);

endmodule

// ==== design/vnu_ctrl_pkg.sv ====
package vnu_ctrl_pkg;

	// scheduler phases of one decoding layer
	// keep this order, the strobe decoder compares ranges of it
	typedef enum logic [3:0] {
		INIT_LOAD   = 4'd0,  // kick off the initial IB-RAM loads
		IB_RAM_PEND = 4'd1,  // wait for the vnu IB-RAMs
		CH_FETCH    = 4'd2,  // channel buffer read
		CH_BUBBLE   = 4'd3,
		MEM_FETCH   = 4'd4,  // c2v fetch then v2c source
		VNU_PIPE    = 4'd5,
		VNU_OUT     = 4'd6,  // last vnu step
		BS_WB       = 4'd7,  // barrel shift write-back
		PAGE_ALIGN  = 4'd8,
		MEM_WB      = 4'd9,
		IDLE        = 4'd10  // wait for end of layer
	} sched_state_e;

endpackage

// ==== design/vnu_ctrl_params.svh ====
`ifndef VNU_CTRL_PARAMS_SVH
`define VNU_CTRL_PARAMS_SVH

////////////////////////////////
// IB-RAM function units
////////////////////////////////
`define VNU_FUNC_NUM 2           // vnu IB-RAM function units
`define VNU_FUNC_CYCLE 3         // phase cycles per vnu function stage

////////////////////////////////
// phase lengths in read_clk cycles
////////////////////////////////
`define CH_BUBBLE_CYCLES 2       // channel buffer bubble
`define MEM_RD_CYCLES 2          // c2v fetch then v2c source select
`define VNU_PIPE_CYCLES 5        // vnu pipe, VNU_OUT counts as the next step
`define BS_CYCLES 2              // barrel shifter takes two cycles

`define LAYER_NUM 3              // layers per iteration, one-hot width

// shortest write hold before the writer's acknowledge counts
`define LOAD_HANDSHAKE_LATENCY 3

`define PHASE_CNT_W 3            // wide enough for the longest timed phase

`endif
